// File: logic/wi23_defs.sv
`default_nettype none

package wi23_defs;

    //////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////

    // Instruction word
    localparam int PC_WIDTH = 32;

    // Register file word and select widths
    localparam int REGFILE_WIDTH = 32;
    localparam int REGFILE_DEPTH = 5;

    //////////////////////////////////////////////////
    // Instruction fields
    //////////////////////////////////////////////////

    // First source register (Rs / Fs)
    localparam int RS_MSB = 25;
    localparam int RS_LSB = 21;

    // Second source register (Rt / Ft, Fd on FP load and store)
    localparam int RT_MSB = 20;
    localparam int RT_LSB = 16;

    // I-format immediate, low half of the word
    localparam int IMM_WIDTH = 16;

    // J-format offset, everything below the opcode
    localparam int OFS_WIDTH = 26;

    //////////////////////////////////////////////////
    // Word types
    //////////////////////////////////////////////////

    // Single precision layout
    localparam int FP_EXP_WIDTH = 8;
    localparam int FP_MAN_WIDTH = 23;

    typedef logic [REGFILE_WIDTH-1:0] word_t;

    // Sign on top, mantissa at the bottom
    typedef struct packed {
        logic                    sign;
        logic [FP_EXP_WIDTH-1:0] exponent;
        logic [FP_MAN_WIDTH-1:0] mantissa;
    } fp_word_t;

endpackage

`default_nettype wire

// File: logic/rf_read_if.sv
`default_nettype none

// Two read ports of one register file
interface rf_read_if #(
    parameter type data_t = wi23_defs::word_t
);
    import wi23_defs::*;

    logic [REGFILE_DEPTH-1:0] read1_sel;
    logic [REGFILE_DEPTH-1:0] read2_sel;
    data_t                    read1_data;
    data_t                    read2_data;

    // Decoder side picks the registers
    modport decode (
        output read1_sel,
        output read2_sel,
        input  read1_data,
        input  read2_data
    );

    // Register file side returns the data
    modport rf (
        input  read1_sel,
        input  read2_sel,
        output read1_data,
        output read2_data
    );

endinterface

`default_nettype wire

// File: logic/rf.sv
`default_nettype none

module rf #(
    parameter type data_t   = wi23_defs::word_t,
    parameter bit  ZERO_REG = 1'b1
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               write,
    input  logic [wi23_defs::REGFILE_DEPTH-1:0] write_sel,
    input  data_t                              write_data,
    output logic                               err,
    rf_read_if.rf                              rd
);
    import wi23_defs::*;

    localparam int NUM_REGS = 2 ** REGFILE_DEPTH;

    data_t regs [NUM_REGS];

    logic zero_hit;
    logic wr_en;
    logic rd1_zero;
    logic rd2_zero;

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    // Register 0 is hardwired only in the integer file
    assign zero_hit = ZERO_REG && (write_sel == '0);
    assign wr_en    = write && !zero_hit;

    // Flag a write that gets thrown away
    assign err = write && zero_hit;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[write_sel] <= write_data;
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    // Combinational, no internal write-through
    assign rd1_zero = ZERO_REG && (rd.read1_sel == '0);
    assign rd2_zero = ZERO_REG && (rd.read2_sel == '0);

    assign rd.read1_data = rd1_zero ? data_t'('0) : regs[rd.read1_sel];
    assign rd.read2_data = rd2_zero ? data_t'('0) : regs[rd.read2_sel];

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Accepted write shows up in the array one cycle later
    a_write_lands: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |=> (regs[$past(write_sel)] == $past(write_data))
    );

endmodule

`default_nettype wire

// File: logic/decode.sv
`default_nettype none

module decode #(
    parameter bit INT_ZERO_REG = 1'b1,
    parameter bit FP_ZERO_REG  = 1'b0
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [wi23_defs::PC_WIDTH-1:0]      inst,

    // Integer write-back
    input  wi23_defs::word_t                    write_in,
    input  logic [wi23_defs::REGFILE_DEPTH-1:0] writesel,
    input  logic                                reg_write,

    // FP write-back
    input  wi23_defs::fp_word_t                 fp_write_in,
    input  logic [wi23_defs::REGFILE_DEPTH-1:0] fp_writesel,
    input  logic                                fp_reg_write,

    // Bypass strobes
    input  logic                                bypass_reg1,
    input  logic                                bypass_reg2,
    input  logic                                fp_bypass_reg1,
    input  logic                                fp_bypass_reg2,

    // Control from the main decoder
    input  logic                                xtend_sel,
    input  logic                                fp_inst,
    input  logic                                fp_int_cvt,
    input  logic                                mem_read,
    input  logic                                mem_write,

    output wi23_defs::word_t                    reg1,
    output wi23_defs::word_t                    reg2,
    output wi23_defs::word_t                    imm,
    output wi23_defs::word_t                    ofs,
    output wi23_defs::fp_word_t                 fp_reg1,
    output wi23_defs::fp_word_t                 fp_reg2,
    output logic                                decode_err
);
    import wi23_defs::*;

    rf_read_if #(.data_t(word_t))    int_rd ();
    rf_read_if #(.data_t(fp_word_t)) fp_rd ();

    word_t    dec_reg1;
    word_t    dec_reg2;
    fp_word_t dec_fp_reg1;
    fp_word_t dec_fp_reg2;

    logic int_err;
    logic fp_err;

    //////////////////////////////////////////////////
    // Integer register file
    //////////////////////////////////////////////////

    assign int_rd.read1_sel = inst[RS_MSB:RS_LSB];
    assign int_rd.read2_sel = inst[RT_MSB:RT_LSB];

    rf #(
        .data_t   (word_t),
        .ZERO_REG (INT_ZERO_REG)
    ) i_rf (
        .clk        (clk),
        .reset      (reset),
        .write      (reg_write),
        .write_sel  (writesel),
        .write_data (write_in),
        .err        (int_err),
        .rd         (int_rd.rf)
    );

    // Forward write-back data still in flight
    assign dec_reg1 = bypass_reg1 ? write_in : int_rd.read1_data;
    assign dec_reg2 = bypass_reg2 ? write_in : int_rd.read2_data;

    //////////////////////////////////////////////////
    // FP register file
    //////////////////////////////////////////////////

    assign fp_rd.read1_sel = inst[RS_MSB:RS_LSB];
    assign fp_rd.read2_sel = inst[RT_MSB:RT_LSB];

    rf #(
        .data_t   (fp_word_t),
        .ZERO_REG (FP_ZERO_REG)
    ) i_fp_rf (
        .clk        (clk),
        .reset      (reset),
        .write      (fp_reg_write),
        .write_sel  (fp_writesel),
        .write_data (fp_write_in),
        .err        (fp_err),
        .rd         (fp_rd.rf)
    );

    assign dec_fp_reg1 = fp_bypass_reg1 ? fp_write_in : fp_rd.read1_data;
    assign dec_fp_reg2 = fp_bypass_reg2 ? fp_write_in : fp_rd.read2_data;

    //////////////////////////////////////////////////
    // Operand selection
    //////////////////////////////////////////////////

    assign reg1 = dec_reg1;

    // FP load/store carries Fd on the second integer operand
    assign reg2 = (fp_inst && (mem_read || mem_write)) ? word_t'(dec_fp_reg2) : dec_reg2;

    // Int to FP conversion takes its source from the integer file
    assign fp_reg1 = (fp_inst && fp_int_cvt) ? fp_word_t'(dec_reg1) : dec_fp_reg1;
    assign fp_reg2 = dec_fp_reg2;

    //////////////////////////////////////////////////
    // Immediates
    //////////////////////////////////////////////////

    // I-format, zero or sign extension
    assign imm = xtend_sel ?
                 {{(REGFILE_WIDTH-IMM_WIDTH){1'b0}}, inst[IMM_WIDTH-1:0]} :
                 {{(REGFILE_WIDTH-IMM_WIDTH){inst[IMM_WIDTH-1]}}, inst[IMM_WIDTH-1:0]};

    // J-format, always signed
    assign ofs = {{(REGFILE_WIDTH-OFS_WIDTH){inst[OFS_WIDTH-1]}}, inst[OFS_WIDTH-1:0]};

    assign decode_err = int_err | fp_err;

    // Both files must report a clean level once out of reset
    a_err_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(decode_err)
    );

endmodule

`default_nettype wire

// File: logic/decode_top.sv
`default_nettype none

module decode_top #(
    parameter bit INT_ZERO_REG = 1'b1,
    parameter bit FP_ZERO_REG  = 1'b0
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [wi23_defs::PC_WIDTH-1:0]      inst,

    input  logic [wi23_defs::REGFILE_WIDTH-1:0] write_in,
    input  logic [wi23_defs::REGFILE_DEPTH-1:0] writesel,
    input  logic                                reg_write,

    input  logic [wi23_defs::REGFILE_WIDTH-1:0] fp_write_in,
    input  logic [wi23_defs::REGFILE_DEPTH-1:0] fp_writesel,
    input  logic                                fp_reg_write,

    input  logic                                bypass_reg1,
    input  logic                                bypass_reg2,
    input  logic                                fp_bypass_reg1,
    input  logic                                fp_bypass_reg2,

    input  logic                                xtend_sel,
    input  logic                                fp_inst,
    input  logic                                fp_int_cvt,
    input  logic                                mem_read,
    input  logic                                mem_write,

    output logic [wi23_defs::REGFILE_WIDTH-1:0] reg1,
    output logic [wi23_defs::REGFILE_WIDTH-1:0] reg2,
    output logic [wi23_defs::REGFILE_WIDTH-1:0] imm,
    output logic [wi23_defs::REGFILE_WIDTH-1:0] ofs,
    // FP words flat at the boundary
    output logic [wi23_defs::REGFILE_WIDTH-1:0] fp_reg1,
    output logic [wi23_defs::REGFILE_WIDTH-1:0] fp_reg2,
    output logic                                decode_err
);

    //////////////////////////////////////////////////
    // Decode stage
    //////////////////////////////////////////////////

    decode #(
        .INT_ZERO_REG (INT_ZERO_REG),
        .FP_ZERO_REG  (FP_ZERO_REG)
    ) i_decode (
        .clk            (clk),
        .reset          (reset),
        .inst           (inst),
        .write_in       (write_in),
        .writesel       (writesel),
        .reg_write      (reg_write),
        .fp_write_in    (fp_write_in),
        .fp_writesel    (fp_writesel),
        .fp_reg_write   (fp_reg_write),
        .bypass_reg1    (bypass_reg1),
        .bypass_reg2    (bypass_reg2),
        .fp_bypass_reg1 (fp_bypass_reg1),
        .fp_bypass_reg2 (fp_bypass_reg2),
        .xtend_sel      (xtend_sel),
        .fp_inst        (fp_inst),
        .fp_int_cvt     (fp_int_cvt),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .reg1           (reg1),
        .reg2           (reg2),
        .imm            (imm),
        .ofs            (ofs),
        .fp_reg1        (fp_reg1),
        .fp_reg2        (fp_reg2),
        .decode_err     (decode_err)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`default_nettype none

// Free-running clock and a synchronous reset pulse
module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge, clear of the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: sim/decode_tb.sv
`default_nettype none

module decode_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import wi23_defs::*;

    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 8;
    localparam int SETTLE_NS    = 5;
    // Reset, then reset_values, int file, fp file, immediates, cross-file
    localparam int TEST_CYCLES  = RESET_CYCLES + 32 + 95 + 68 + 42 + 32 + 1;
    localparam int TIMEOUT_NS   = TEST_CYCLES * PERIOD_NS + 2000;

    logic clk, reset, reg_write, fp_reg_write, decode_err;
    logic bypass_reg1, bypass_reg2, fp_bypass_reg1, fp_bypass_reg2;
    logic xtend_sel, fp_inst, fp_int_cvt, mem_read, mem_write;
    logic [PC_WIDTH-1:0]      inst;
    logic [REGFILE_DEPTH-1:0] writesel, fp_writesel;
    word_t write_in, fp_write_in, reg1, reg2, imm, ofs, fp_reg1, fp_reg2;

    // Expected contents of both files
    word_t  int_model [32];
    word_t  fp_model [32];
    int     errors;
    int     checks;
    integer seed;

    tb_clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) i_clk (.clk, .reset);

    decode_top #(.INT_ZERO_REG(1'b1), .FP_ZERO_REG(1'b0)) dut (.*);

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    task automatic compare(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic drive_idle();
        {reg_write, fp_reg_write, bypass_reg1, bypass_reg2} = '0;
        {fp_bypass_reg1, fp_bypass_reg2, xtend_sel, fp_inst} = '0;
        {fp_int_cvt, mem_read, mem_write} = '0;
        {inst, writesel, fp_writesel, write_in, fp_write_in} = '0;
    endtask

    task automatic set_sources(input int rs, input int rt);
        inst = '0;
        inst[RS_MSB:RS_LSB] = REGFILE_DEPTH'(rs);
        inst[RT_MSB:RT_LSB] = REGFILE_DEPTH'(rt);
    endtask

    // New inputs on the falling edge, look a little later
    task automatic next_step(input int rs, input int rt);
        @(negedge clk);
        drive_idle();
        set_sources(rs, rt);
    endtask

    task automatic log_result(input string name, input int start);
        $display("%-18s %s, %0d errors", name, (errors == start) ? "ok" : "failed",
                 errors - start);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic reset_values();
        int start;
        start = errors;
        for (int r = 0; r < 32; r++) begin
            next_step(r, r);
            #(SETTLE_NS);
            compare("reg1", reg1, '0);
            compare("reg2", reg2, '0);
            compare("fp_reg1", fp_reg1, '0);
            compare("fp_reg2", fp_reg2, '0);
            compare("decode_err", decode_err, '0);
        end
        log_result("reset_values", start);
    endtask

    task automatic int_file_rw();
        int    start;
        word_t data;
        start = errors;
        for (int r = 1; r < 32; r++) begin
            data = $random(seed);
            next_step(r, 0);
            {reg_write, writesel, write_in} = {1'b1, REGFILE_DEPTH'(r), data};
            #(SETTLE_NS);
            // Old contents until the edge
            compare("reg1", reg1, int_model[r]);
            compare("reg2", reg2, '0);
            compare("decode_err", decode_err, '0);
            next_step(r, r);
            int_model[r] = data;
            #(SETTLE_NS);
            compare("reg1", reg1, data);
            compare("reg2", reg2, data);
        end
        for (int r = 1; r < 32; r++) begin
            next_step(r, 32 - r);
            #(SETTLE_NS);
            compare("reg1", reg1, int_model[r]);
            compare("reg2", reg2, int_model[32 - r]);
        end
        // Register 0 is hardwired
        next_step(0, 0);
        {reg_write, writesel, write_in} = {1'b1, 5'd0, 32'hffff_ffff};
        #(SETTLE_NS);
        compare("decode_err", decode_err, 1);
        compare("reg1", reg1, '0);
        next_step(0, 0);
        #(SETTLE_NS);
        compare("reg1", reg1, '0);
        compare("decode_err", decode_err, '0);
        log_result("int_file_rw", start);
    endtask

    task automatic fp_file_bypass();
        int    start;
        word_t data;
        start = errors;
        for (int r = 0; r < 32; r++) begin
            data = $random(seed);
            next_step(r, r);
            {fp_reg_write, fp_writesel, fp_write_in} = {1'b1, REGFILE_DEPTH'(r), data};
            // Alternate the strobe between the two operands
            fp_bypass_reg1 = (r % 2 == 0);
            fp_bypass_reg2 = (r % 2 == 1);
            #(SETTLE_NS);
            compare("fp_reg1", fp_reg1, (r % 2 == 0) ? data : fp_model[r]);
            compare("fp_reg2", fp_reg2, (r % 2 == 1) ? data : fp_model[r]);
            compare("decode_err", decode_err, '0);
            next_step(r, r);
            fp_model[r] = data;
            #(SETTLE_NS);
            compare("fp_reg1", fp_reg1, data);
            compare("fp_reg2", fp_reg2, data);
        end
        data = $random(seed);
        next_step(5, 5);
        {reg_write, writesel, write_in, bypass_reg2} = {1'b1, 5'd5, data, 1'b1};
        #(SETTLE_NS);
        compare("reg2", reg2, data);
        compare("reg1", reg1, int_model[5]);
        next_step(5, 5);
        int_model[5] = data;
        #(SETTLE_NS);
        compare("reg1", reg1, data);
        // Same again on the first integer operand
        data = $random(seed);
        next_step(6, 6);
        {reg_write, writesel, write_in, bypass_reg1} = {1'b1, 5'd6, data, 1'b1};
        #(SETTLE_NS);
        compare("reg1", reg1, data);
        compare("reg2", reg2, int_model[6]);
        next_step(6, 6);
        int_model[6] = data;
        #(SETTLE_NS);
        compare("reg2", reg2, data);
        log_result("fp_file_bypass", start);
    endtask

    task automatic check_imm(input word_t word, input logic zero_ext);
        word_t exp_imm;
        word_t exp_ofs;
        int    half_val;
        int    ofs_val;
        // Two's complement value of each field
        half_val = word[15:0];
        if (!zero_ext && word[15]) begin
            half_val = half_val - 65536;
        end
        ofs_val = word[25:0];
        if (word[25]) begin
            ofs_val = ofs_val - (1 << 26);
        end
        exp_imm = word_t'(half_val);
        exp_ofs = word_t'(ofs_val);
        @(negedge clk);
        drive_idle();
        {inst, xtend_sel} = {word, zero_ext};
        #(SETTLE_NS);
        compare("imm", imm, exp_imm);
        compare("ofs", ofs, exp_ofs);
    endtask

    task automatic immediate_forms();
        int    start;
        word_t draw;
        start = errors;
        check_imm(32'h0200_8000, 1'b0);
        check_imm(32'hfdff_7fff, 1'b1);
        for (int n = 0; n < 40; n++) begin
            draw = $random(seed);
            check_imm($random(seed), draw[0]);
        end
        log_result("immediate_forms", start);
    endtask

    task automatic cross_file_select();
        int start;
        int a;
        int b;
        start = errors;
        for (int k = 0; k < 8; k++) begin
            a = k + 1;
            b = 31 - k;
            next_step(a, b);
            {fp_inst, mem_write} = 2'b11;
            #(SETTLE_NS);
            compare("reg2", reg2, fp_model[b]);
            compare("reg1", reg1, int_model[a]);
            compare("fp_reg1", fp_reg1, fp_model[a]);
            next_step(a, b);
            {fp_inst, mem_read} = 2'b11;
            #(SETTLE_NS);
            compare("reg2", reg2, fp_model[b]);
            next_step(a, b);
            {fp_inst, fp_int_cvt} = 2'b11;
            #(SETTLE_NS);
            compare("fp_reg1", fp_reg1, int_model[a]);
            compare("reg2", reg2, int_model[b]);
            compare("fp_reg2", fp_reg2, fp_model[b]);
            // Without fp_inst nothing crosses over
            next_step(a, b);
            {mem_read, mem_write, fp_int_cvt} = 3'b111;
            #(SETTLE_NS);
            compare("reg2", reg2, int_model[b]);
            compare("fp_reg1", fp_reg1, fp_model[a]);
        end
        log_result("cross_file_select", start);
    endtask

    //////////////////////////////////////////////////
    // Sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        seed   = 32'ha684;
        errors = 0;
        checks = 0;
        drive_idle();
        for (int r = 0; r < 32; r++) begin
            int_model[r] = '0;
            fp_model[r]  = '0;
        end
        wait (reset === 1'b0);
        reset_values();
        int_file_rw();
        fp_file_bypass();
        immediate_forms();
        cross_file_select();
        @(negedge clk);
        drive_idle();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
logic/wi23_defs.sv
logic/rf_read_if.sv
logic/rf.sv
logic/decode.sv
logic/decode_top.sv
sim/tb_clock_gen.sv
sim/decode_tb.sv

// File: Bender.yml
package:
  name: wi23_decode

sources:
  # RTL in compile order
  - logic/wi23_defs.sv
  - logic/rf_read_if.sv
  - logic/rf.sv
  - logic/decode.sv
  - logic/decode_top.sv

  # Testbench, top module decode_tb
  - target: test
    files:
      - sim/tb_clock_gen.sv
      - sim/decode_tb.sv
